//--- source/rf_pkg.sv
`default_nettype none

package rf_pkg;

    // --------------------
    // Widths with a meaning
    // --------------------

    // Subsystem address, the top bit selects one of the two banks
    typedef logic [6:0] rf_addr_t;

    // Address inside a single 64 entry bank
    typedef logic [5:0] bank_addr_t;

    // Logical data word as seen at the subsystem ports
    typedef logic [4:0] rf_data_t;

    // Word at the physical width of the array macro
    typedef logic [7:0] phys_data_t;

    // Depth of the memory reset synchronizer in each bank.
    // The controller also uses it to release reset early enough
    localparam int unsigned MEM_RST_SYNC_STAGES = 2;

    // --------------------
    // Access bundles
    // --------------------

    // Write port of one bank
    typedef struct packed {
        logic       we;
        bank_addr_t waddr;
        rf_data_t   wdata;
    } rf_wr_t;

    // Read port of one bank
    typedef struct packed {
        logic       re;
        bank_addr_t raddr;
    } rf_rd_t;

    // Power-gate sequencer states, sleep runs down the list and wake wraps around
    typedef enum logic [2:0] {
        PG_ACTIVE,
        PG_ISOLATE,
        PG_PWR_DOWN,
        PG_OFF,
        PG_PWR_UP,
        PG_MEM_RESET
    } pg_state_t;

endpackage

`default_nettype wire

//--- source/rf_array_64x8.sv
`default_nettype none

// Behavioral model of the 64x8 two-port register file macro.
// Writes happen on wclk, reads land in an output register on rclk
module rf_array_64x8 import rf_pkg::*; #(
    parameter int unsigned CHAIN_DELAY = 2
) (
     input  logic       wclk
    ,input  logic       rclk
    ,input  logic       reset
    ,input  logic       mem_reset
    ,input  logic       isolation
    ,input  logic       pwr_enable_b_in
    ,input  rf_wr_t     wr
    ,input  phys_data_t wdata_phys
    ,input  rf_rd_t     rd
    ,output phys_data_t rdata
    ,output logic       pwr_enable_b_out
);

    localparam int unsigned DEPTH = 2 ** $bits(bank_addr_t);

    phys_data_t mem [DEPTH];
    phys_data_t rdata_q;

    // One flop per stage of the power switch chain
    logic [CHAIN_DELAY-1:0] chain_q;

    logic wr_accept;
    logic rd_accept;

    // The array is powered only while the active low enable is low.
    // Isolation also shuts both ports
    assign wr_accept = wr.we && !isolation && !pwr_enable_b_in;
    assign rd_accept = rd.re && !isolation && !pwr_enable_b_in;

    // --------------------
    // Write side
    // --------------------

    // Storage is lost whenever the supply is switched off.
    // Reset stands for the initial power-on, so the model starts from zero too
    always_ff @(posedge wclk) begin
        if (reset || pwr_enable_b_in) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_accept) begin
            mem[wr.waddr] <= wdata_phys;
        end
    end

    // --------------------
    // Read side
    // --------------------

    // Output register, cleared by the synchronized memory reset
    always_ff @(posedge rclk) begin
        if (mem_reset) begin
            rdata_q <= '0;
        end else if (rd_accept) begin
            rdata_q <= mem[rd.raddr];
        end
    end

    // Isolation clamps the output so a powered down bank never drives garbage
    assign rdata = isolation ? '0 : rdata_q;

    // --------------------
    // Power enable chain
    // --------------------

    // The enable ripples through the switch segments before it leaves the macro.
    // After reset the chain reads as off, so the first wake waits for the full trip
    always_ff @(posedge rclk) begin
        if (reset) begin
            chain_q <= '1;
        end else begin
            chain_q[0] <= pwr_enable_b_in;
            for (int i = 1; i < CHAIN_DELAY; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    assign pwr_enable_b_out = chain_q[CHAIN_DELAY-1];

    // The controller must have isolated the bank before any segment of the
    // chain turns off, so a write attempt during power-off is already fenced
    a_no_write_powered_off: assert property (
        @(posedge wclk) disable iff (reset)
        (pwr_enable_b_in && wr.we) |-> isolation
    ) else $error("write attempted on a powered off bank without isolation");

endmodule

`default_nettype wire

//--- source/rf_pg_64x5.sv
`default_nettype none

// 64x5 register file bank on top of the 64x8 macro.
// The logical word is padded up to the macro width and sliced back down
module rf_pg_64x5 import rf_pkg::*; #(
    parameter int unsigned CHAIN_DELAY = 2
) (
     input  logic     wclk
    ,input  logic     rclk
    ,input  logic     reset
    ,input  logic     mem_reset
    ,input  logic     isolation
    ,input  logic     pwr_enable_b_in
    ,input  rf_wr_t   wr
    ,input  rf_rd_t   rd
    ,output rf_data_t rdata
    ,output logic     pwr_enable_b_out
);

    localparam int unsigned PAD_W = $bits(phys_data_t) - $bits(rf_data_t);

    phys_data_t wdata_phys;
    phys_data_t rdata_phys;

    // Synchronizer for the memory reset, in the read clock domain
    logic [MEM_RST_SYNC_STAGES-1:0] mem_reset_sync;

    // Upper macro bits are unused and always written as zero
    assign wdata_phys = {{PAD_W{1'b0}}, wr.wdata};

    // --------------------
    // Memory reset sync
    // --------------------

    // Preset by reset so the macro stays in reset until the
    // controller explicitly lets go
    always_ff @(posedge rclk) begin
        if (reset) begin
            mem_reset_sync <= '1;
        end else begin
            mem_reset_sync <= {mem_reset_sync[MEM_RST_SYNC_STAGES-2:0], mem_reset};
        end
    end

    rf_array_64x8 #(
        .CHAIN_DELAY (CHAIN_DELAY)
    ) i_rf (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.reset            (reset)
        ,.mem_reset        (mem_reset_sync[MEM_RST_SYNC_STAGES-1])
        ,.isolation        (isolation)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.wr               (wr)
        ,.wdata_phys       (wdata_phys)
        ,.rd               (rd)
        ,.rdata            (rdata_phys)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Only the logical bits come back out
    assign rdata = rdata_phys[$bits(rf_data_t)-1:0];

endmodule

`default_nettype wire

//--- source/rf_pg_ctrl.sv
`default_nettype none

// Power-gate controller for both banks.
// Sleep order is isolate, switch off, wait for the chain.
// Wake order is switch on, wait for the chain, hold memory reset, release isolation
module rf_pg_ctrl import rf_pkg::*; #(
    parameter int unsigned RESET_CYCLES = 4
) (
     input  logic rclk
    ,input  logic reset
    ,input  logic sleep_req
    ,input  logic pwr_chain_ack
    ,output logic isolation
    ,output logic pwr_enable_b
    ,output logic mem_reset
    ,output logic ready
);

    // Memory reset is released early in PG_MEM_RESET so the bank synchronizers
    // have drained by the time isolation drops
    localparam int unsigned HOLD_CYCLES = RESET_CYCLES + MEM_RST_SYNC_STAGES;
    localparam int unsigned CNT_W       = $clog2(HOLD_CYCLES + 1);

    pg_state_t state_q;
    pg_state_t state_next;

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_next;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_next = state_q;
        case (state_q)
            PG_ACTIVE: begin
                if (sleep_req) begin
                    state_next = PG_ISOLATE;
                end
            end
            // Isolation settles for one cycle before power goes away
            PG_ISOLATE: begin
                state_next = PG_PWR_DOWN;
            end
            // Enable is high here, wait until the far end of the chain is off
            PG_PWR_DOWN: begin
                if (pwr_chain_ack) begin
                    state_next = PG_OFF;
                end
            end
            PG_OFF: begin
                if (!sleep_req) begin
                    state_next = PG_PWR_UP;
                end
            end
            // Enable is low here, wait until every segment is back on
            PG_PWR_UP: begin
                if (!pwr_chain_ack) begin
                    state_next = PG_MEM_RESET;
                end
            end
            PG_MEM_RESET: begin
                if (cnt_q == CNT_W'(HOLD_CYCLES - 1)) begin
                    state_next = PG_ACTIVE;
                end
            end
            default: begin
                state_next = PG_PWR_UP;
            end
        endcase
    end

    // Counter runs only while staying in PG_MEM_RESET and restarts on entry
    always_comb begin
        cnt_next = '0;
        if (state_q == PG_MEM_RESET && state_next == PG_MEM_RESET) begin
            cnt_next = cnt_q + 1'b1;
        end
    end

    // --------------------
    // State and outputs
    // --------------------

    // All outputs are flops decoded from the next state, so they change
    // on the edge that enters a state
    always_ff @(posedge rclk) begin
        if (reset) begin
            state_q      <= PG_PWR_UP;
            cnt_q        <= '0;
            isolation    <= 1'b1;
            pwr_enable_b <= 1'b0;
            mem_reset    <= 1'b1;
            ready        <= 1'b0;
        end else begin
            state_q      <= state_next;
            cnt_q        <= cnt_next;
            isolation    <= state_next != PG_ACTIVE;
            ready        <= state_next == PG_ACTIVE;
            pwr_enable_b <= state_next == PG_PWR_DOWN || state_next == PG_OFF;
            // Held for RESET_CYCLES inside PG_MEM_RESET, then low while the sync drains
            mem_reset    <= state_next == PG_PWR_UP ||
                            (state_next == PG_MEM_RESET && cnt_next < CNT_W'(RESET_CYCLES));
        end
    end

    // Ready also promises that the far end of the chain is powered again
    a_ready_not_isolated: assert property (
        @(posedge rclk) disable iff (reset)
        ready |-> (!isolation && !pwr_chain_ack)
    ) else $error("ready is high while the banks are isolated or unpowered");

    // The whole chain, including the delayed return, must be fenced by isolation
    a_isolated_while_unpowered: assert property (
        @(posedge rclk) disable iff (reset)
        (pwr_enable_b || pwr_chain_ack) |-> isolation
    ) else $error("a bank is unpowered while isolation is low");

endmodule

`default_nettype wire

//--- source/rf_subsys_top.sv
`default_nettype none

// 128x5 power-gated register file built from two 64x5 banks.
// Address bit 6 picks the bank, power enable daisy chains bank 0 then bank 1
module rf_subsys_top import rf_pkg::*; #(
    parameter int unsigned CHAIN_DELAY  = 2,
    parameter int unsigned RESET_CYCLES = 4
) (
     input  logic     wclk
    ,input  logic     rclk
    ,input  logic     reset
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,input  logic     sleep_req
    ,output rf_data_t rdata
    ,output logic     ready
);

    localparam int unsigned NUM_BANKS = 2;
    localparam int unsigned BANK_BIT  = $bits(bank_addr_t);

    logic isolation;
    logic mem_reset;

    // Chain taps, index 0 leaves the controller and the last one returns to it
    logic pwr_chain [NUM_BANKS+1];

    rf_wr_t   wr_bank    [NUM_BANKS];
    rf_rd_t   rd_bank    [NUM_BANKS];
    rf_data_t rdata_bank [NUM_BANKS];

    // Bank that the last accepted read went to
    logic rd_bank_q;

    // --------------------
    // Power control
    // --------------------

    rf_pg_ctrl #(
        .RESET_CYCLES (RESET_CYCLES)
    ) i_pg_ctrl (
         .rclk          (rclk)
        ,.reset         (reset)
        ,.sleep_req     (sleep_req)
        ,.pwr_chain_ack (pwr_chain[NUM_BANKS])
        ,.isolation     (isolation)
        ,.pwr_enable_b  (pwr_chain[0])
        ,.mem_reset     (mem_reset)
        ,.ready         (ready)
    );

    // --------------------
    // Banks
    // --------------------

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // Only the addressed bank sees the strobe, the rest of the bundle is shared
        assign wr_bank[b] = '{
            we:    we && (waddr[BANK_BIT] == 1'(b)),
            waddr: waddr[BANK_BIT-1:0],
            wdata: wdata
        };
        assign rd_bank[b] = '{
            re:    re && (raddr[BANK_BIT] == 1'(b)),
            raddr: raddr[BANK_BIT-1:0]
        };

        rf_pg_64x5 #(
            .CHAIN_DELAY (CHAIN_DELAY)
        ) i_bank (
             .wclk             (wclk)
            ,.rclk             (rclk)
            ,.reset            (reset)
            ,.mem_reset        (mem_reset)
            ,.isolation        (isolation)
            ,.pwr_enable_b_in  (pwr_chain[b])
            ,.wr               (wr_bank[b])
            ,.rd               (rd_bank[b])
            ,.rdata            (rdata_bank[b])
            ,.pwr_enable_b_out (pwr_chain[b+1])
        );
    end

    // --------------------
    // Read return
    // --------------------

    // Select is captured on the same edge as the bank output register,
    // and holds with re low so rdata keeps its last value
    always_ff @(posedge rclk) begin
        if (reset) begin
            rd_bank_q <= 1'b0;
        end else if (re) begin
            rd_bank_q <= raddr[BANK_BIT];
        end
    end

    assign rdata = rdata_bank[rd_bank_q];

endmodule

`default_nettype wire

//--- testbench/rf_subsys_tb.sv
`default_nettype none

// Testbench for the power-gated 128x5 register file subsystem
module rf_subsys_tb import rf_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 8;
    localparam int RST_CYCLES      = 10;
    localparam int ENTRIES         = 128;
    localparam int NUM_RANDOM      = 400;
    localparam int NUM_RANDOM_WAKE = 200;
    localparam int OFF_CYCLES      = 32;
    localparam int WAIT_LIMIT      = 64;

    // Every phase in cycles, the three power waits get the margin
    localparam int TEST_CYCLES = RST_CYCLES + 4 * ENTRIES + NUM_RANDOM + NUM_RANDOM_WAKE
                                 + OFF_CYCLES;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 3 * WAIT_LIMIT) * CLK_PERIOD + 100;

    logic     clk = 1'b0;
    logic     reset;
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    logic     sleep_req;
    rf_data_t rdata;
    logic     ready;

    // Reference model of the storage, cleared when the banks lose power
    rf_data_t model_mem [ENTRIES];
    logic     written   [ENTRIES];

    // Model of the read output register as seen while the banks are not isolated
    rf_data_t exp_q;

    logic [15:0] lfsr_state = 16'd1810;

    rf_subsys_top #(
        .CHAIN_DELAY  (2),
        .RESET_CYCLES (4)
    ) UUT (
        .wclk      (clk),
        .rclk      (clk),
        .reset     (reset),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .re        (re),
        .raddr     (raddr),
        .sleep_req (sleep_req),
        .rdata     (rdata),
        .ready     (ready)
    );

    // Write and read clocks share this one clock
    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------

    // 16 bit Fibonacci LFSR, taps 16 14 13 11, one new bit per call
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (expected !== actual) begin
            $display("ERR time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < ENTRIES; i++) begin
            model_mem[i] = '0;
            written[i]   = 1'b0;
        end
    endtask

    // One access cycle, called at a falling edge and returning at the next one.
    // The read sees the old word when it hits the address being written
    task automatic run_cycle(input logic w_en, input rf_addr_t w_addr, input rf_data_t w_data,
                             input logic r_en, input rf_addr_t r_addr);
        logic was_ready;
        was_ready = ready;
        we    = w_en;
        waddr = w_addr;
        wdata = w_data;
        re    = r_en;
        raddr = r_addr;
        if (r_en && was_ready) begin
            exp_q = written[r_addr] ? model_mem[r_addr] : '0;
        end
        if (w_en && was_ready) begin
            model_mem[w_addr] = w_data;
            written[w_addr]   = 1'b1;
        end
        @(negedge clk);
        // Contents are gone once a sleep starts
        if (was_ready && !ready) begin
            clear_model();
        end
        // The wake sequence clears the output register as well
        if (!ready) begin
            exp_q = '0;
        end
        check_value("rdata", ready ? exp_q : '0, rdata);
    endtask

    // Random mix of writes, reads, both, and idle cycles with re low
    task automatic random_op();
        logic [1:0] op;
        rf_addr_t   w_addr;
        rf_data_t   w_data;
        rf_addr_t   r_addr;
        op     = 2'(rand_bits(2));
        w_addr = rf_addr_t'(rand_bits(7));
        w_data = rf_data_t'(rand_bits(5));
        r_addr = rf_addr_t'(rand_bits(7));
        run_cycle(op == 2'd0 || op == 2'd2, w_addr, w_data, op == 2'd1 || op == 2'd2, r_addr);
    endtask

    // Keeps traffic going while the power sequence runs
    task automatic wait_for_ready(input logic level);
        int count;
        count = 0;
        while (ready !== level && count < WAIT_LIMIT) begin
            random_op();
            count++;
        end
        if (ready !== level) begin
            $display("Timed out after %0d cycles waiting for ready to become %0b",
                     WAIT_LIMIT, level);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic read_all_zero();
        for (int a = 0; a < ENTRIES; a++) begin
            run_cycle(1'b0, '0, '0, 1'b1, rf_addr_t'(a));
            check_value("rdata", '0, rdata);
        end
    endtask

    task automatic fill_and_read_back();
        for (int a = 0; a < ENTRIES; a++) begin
            run_cycle(1'b1, rf_addr_t'(a), rf_data_t'(rand_bits(5)), 1'b0, '0);
        end
        for (int a = 0; a < ENTRIES; a++) begin
            run_cycle(1'b0, '0, '0, 1'b1, rf_addr_t'(a));
        end
    endtask

    // --------------------
    // Watchdog
    // --------------------

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("Verification failed");
        $fatal(1);
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        reset     = 1'b1;
        we        = 1'b0;
        waddr     = '0;
        wdata     = '0;
        re        = 1'b0;
        raddr     = '0;
        sleep_req = 1'b0;
        exp_q     = '0;
        clear_model();

        repeat (RST_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_value("ready", 1'b0, ready);
        check_value("rdata", '0, rdata);

        // First wake out of reset, then every entry must be empty
        wait_for_ready(1'b1);
        read_all_zero();

        // Both banks full of data, then random traffic on top
        fill_and_read_back();
        repeat (NUM_RANDOM) random_op();

        // Sleep, with accesses that must all be ignored
        sleep_req = 1'b1;
        wait_for_ready(1'b0);
        repeat (OFF_CYCLES) begin
            random_op();
            check_value("ready", 1'b0, ready);
        end

        // Wake, nothing survives the power-down
        sleep_req = 1'b0;
        wait_for_ready(1'b1);
        read_all_zero();
        repeat (NUM_RANDOM_WAKE) random_op();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
source/rf_pkg.sv
source/rf_array_64x8.sv
source/rf_pg_64x5.sv
source/rf_pg_ctrl.sv
source/rf_subsys_top.sv
testbench/rf_subsys_tb.sv
